// ==== capture_pkg.sv ====
package capture_pkg;

   // Sample format as delivered by the front end.
   localparam int SAMPLE_WIDTH = 3;

   // Samples packed into each RAM word.
   localparam int SAMPLES_PER_WORD = 8;

   localparam int WORD_WIDTH = SAMPLE_WIDTH * SAMPLES_PER_WORD;

   typedef logic [SAMPLE_WIDTH-1:0] sample_t;

   // Oldest sample of a word sits in the top bits.
   typedef logic [WORD_WIDTH-1:0] word_t;

   // Bank operating mode, driven by the controller.
   typedef enum logic {
      MODE_WRITING  = 1'b0,
      MODE_PLAYBACK = 1'b1
   } mode_t;

endpackage

// ==== mem_bank_ram.sv ====
`timescale 1ns/10ps

module mem_bank_ram
   import capture_pkg::*;
#(
   parameter int NUM_WORDS = 64
) (
   input  logic                         clk,
   input  logic [$clog2(NUM_WORDS)-1:0] address,
   input  word_t                        data,
   input  logic                         wren,
   output word_t                        q
);

   word_t mem [NUM_WORDS];

   // Read returns the old contents on a write to the same address.
   always_ff @(posedge clk) begin
      if (wren) begin
         mem[address] <= data;
      end
      q <= mem[address];
   end

endmodule

// ==== sample_decimator.sv ====
`timescale 1ns/10ps

module sample_decimator
   import capture_pkg::*;
#(
   parameter int DECIMATION = 3
) (
   input  logic    clk,
   input  logic    reset,
   input  sample_t sample_in,
   input  logic    sample_strobe,
   output logic    data_available,
   output sample_t data
);

   localparam int COUNT_WIDTH = (DECIMATION > 1) ? $clog2(DECIMATION) : 1;
   localparam logic [COUNT_WIDTH-1:0] LAST_COUNT = COUNT_WIDTH'(DECIMATION - 1);

   logic [COUNT_WIDTH-1:0] strobe_count;
   logic                   keep;

   // First strobe after reset passes, then every DECIMATION-th one.
   assign keep = sample_strobe && (strobe_count == '0);

   always_ff @(posedge clk) begin
      if (reset) begin
         strobe_count   <= '0;
         data_available <= 1'b0;
      end else begin
         data_available <= keep;
         if (sample_strobe) begin
            strobe_count <= (strobe_count == LAST_COUNT) ? '0 : strobe_count + 1'b1;
         end
      end
   end

   // Sample registered alongside the pulse.
   always_ff @(posedge clk) begin
      if (keep) begin
         data <= sample_in;
      end
   end

endmodule

// ==== mem_bank.sv ====
`timescale 1ns/10ps

module mem_bank
   import capture_pkg::*;
#(
   parameter int NUM_WORDS       = 64,
   parameter int SAMPLES_PER_ACQ = 256
) (
   input  logic    clk,
   input  logic    reset,
   input  mode_t   mode,
   input  logic    data_available,
   input  sample_t data_in,
   output logic    ready,
   output logic    frame_start,
   output logic    frame_end,
   output logic    sample_valid,
   output sample_t data_out
);

   localparam int ADDR_WIDTH   = $clog2(NUM_WORDS);
   localparam int ACQ_WIDTH    = $clog2(SAMPLES_PER_ACQ + 1);
   localparam int PLAY_WIDTH   = $clog2(SAMPLES_PER_ACQ);
   localparam int OFFSET_WIDTH = $clog2(SAMPLES_PER_WORD);

   localparam logic [ADDR_WIDTH-1:0]   LAST_ADDR   = ADDR_WIDTH'(NUM_WORDS - 1);
   localparam logic [OFFSET_WIDTH-1:0] LAST_OFFSET = OFFSET_WIDTH'(SAMPLES_PER_WORD - 1);
   localparam logic [OFFSET_WIDTH-1:0] PRIME_OFFSET = OFFSET_WIDTH'(SAMPLES_PER_WORD - 2);
   localparam logic [ACQ_WIDTH-1:0]    ACQ_FULL    = ACQ_WIDTH'(SAMPLES_PER_ACQ);
   localparam logic [PLAY_WIDTH-1:0]   LAST_SAMPLE = PLAY_WIDTH'(SAMPLES_PER_ACQ - 1);
   // Second sample of the last word in a frame.
   localparam logic [PLAY_WIDTH-1:0]   REWIND_AT   =
      PLAY_WIDTH'(SAMPLES_PER_ACQ - SAMPLES_PER_WORD + 1);

   logic [ADDR_WIDTH-1:0]   wr_addr;
   logic [ADDR_WIDTH-1:0]   rd_addr;
   logic [ADDR_WIDTH-1:0]   start_addr;
   logic [ADDR_WIDTH-1:0]   ram_addr;
   logic [OFFSET_WIDTH-1:0] wr_offset;
   logic [OFFSET_WIDTH-1:0] rd_offset;
   logic [ACQ_WIDTH-1:0]    acq_count;
   logic [PLAY_WIDTH-1:0]   play_count;
   word_t                   buffer;
   word_t                   ram_q;
   mode_t                   mode_q;
   logic                    wr_pending;
   logic                    wr_full;
   logic                    ram_wren;
   logic                    streaming;
   logic                    accept;
   logic                    word_done;
   logic                    enter_play;
   logic                    word_load;

   function automatic logic [ADDR_WIDTH-1:0] next_addr(input logic [ADDR_WIDTH-1:0] addr);
      return (addr == LAST_ADDR) ? '0 : addr + 1'b1;
   endfunction

   assign accept     = data_available && (mode == MODE_WRITING);
   assign word_done  = accept && (wr_offset == LAST_OFFSET);
   assign enter_play = (mode == MODE_PLAYBACK) && (mode_q == MODE_WRITING);
   assign word_load  = (mode == MODE_PLAYBACK) && !enter_play && (rd_offset == LAST_OFFSET);
   assign ram_wren   = wr_pending && (mode == MODE_WRITING);
   assign ram_addr   = (mode == MODE_PLAYBACK) ? rd_addr : wr_addr;

   mem_bank_ram #(
      .NUM_WORDS(NUM_WORDS)
   ) ram (
      .clk    (clk),
      .address(ram_addr),
      .data   (buffer),
      .wren   (ram_wren),
      .q      (ram_q)
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         mode_q     <= MODE_WRITING;
         wr_pending <= 1'b0;
         wr_full    <= 1'b0;
         wr_offset  <= '0;
         wr_addr    <= '0;
         start_addr <= '0;
         acq_count  <= '0;
      end else begin
         mode_q     <= mode;
         wr_pending <= word_done;
         wr_full    <= (acq_count == ACQ_FULL);
         if (mode == MODE_PLAYBACK) begin
            wr_offset <= '0;
            acq_count <= '0;
         end else begin
            if (mode_q == MODE_PLAYBACK) begin
               // Next acquisition starts where writing left off.
               start_addr <= wr_addr;
            end
            if (accept) begin
               wr_offset <= (wr_offset == LAST_OFFSET) ? '0 : wr_offset + 1'b1;
               if (acq_count != ACQ_FULL) begin
                  acq_count <= acq_count + 1'b1;
               end
            end
            if (ram_wren) begin
               wr_addr <= next_addr(wr_addr);
               // Ring is full, so the oldest word drops out.
               if (wr_full) begin
                  start_addr <= next_addr(start_addr);
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (mode == MODE_PLAYBACK) begin
         if (word_load) begin
            buffer <= ram_q;
         end else begin
            buffer <= {buffer[WORD_WIDTH-SAMPLE_WIDTH-1:0], sample_t'(0)};
         end
      end else if (accept) begin
         buffer <= {buffer[WORD_WIDTH-SAMPLE_WIDTH-1:0], data_in};
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_addr    <= '0;
         rd_offset  <= '0;
         play_count <= '0;
         streaming  <= 1'b0;
      end else if (mode == MODE_WRITING) begin
         streaming <= 1'b0;
      end else if (enter_play) begin
         // First word reaches ram_q two cycles after this reload.
         rd_addr    <= start_addr;
         rd_offset  <= PRIME_OFFSET;
         play_count <= '0;
      end else begin
         rd_offset <= (rd_offset == LAST_OFFSET) ? '0 : rd_offset + 1'b1;
         if (word_load) begin
            streaming <= 1'b1;
         end
         if (streaming) begin
            play_count <= (play_count == LAST_SAMPLE) ? '0 : play_count + 1'b1;
            // Fetch ahead, wrapping to the ring start for the next frame.
            if (rd_offset == OFFSET_WIDTH'(1)) begin
               rd_addr <= (play_count == REWIND_AT) ? start_addr : next_addr(rd_addr);
            end
         end
      end
   end

   assign ready        = (mode == MODE_WRITING) && (acq_count == ACQ_FULL);
   assign sample_valid = (mode == MODE_PLAYBACK) && streaming;
   assign frame_start  = sample_valid && (play_count == '0);
   assign frame_end    = sample_valid && (play_count == LAST_SAMPLE);
   assign data_out     = buffer[WORD_WIDTH-1 -: SAMPLE_WIDTH];

endmodule

// ==== acq_controller.sv ====
`timescale 1ns/10ps

module acq_controller
   import capture_pkg::*;
#(
   parameter int NUM_REPLAYS = 2
) (
   input  logic  clk,
   input  logic  reset,
   input  logic  trigger,
   input  logic  ready,
   input  logic  frame_end,
   output mode_t mode,
   output logic  playing
);

   localparam int COUNT_WIDTH = (NUM_REPLAYS > 1) ? $clog2(NUM_REPLAYS) : 1;
   localparam logic [COUNT_WIDTH-1:0] LAST_REPLAY = COUNT_WIDTH'(NUM_REPLAYS - 1);

   typedef enum logic [1:0] {
      ST_ARMED,
      ST_PLAYBACK,
      ST_RETURN
   } state_t;

   state_t                 state;
   state_t                 state_next;
   logic [COUNT_WIDTH-1:0] replay_count;
   logic                   last_frame;

   assign last_frame = (replay_count == LAST_REPLAY);

   always_comb begin
      state_next = state;
      case (state)
         ST_ARMED: begin
            if (trigger && ready) begin
               state_next = ST_PLAYBACK;
            end
         end
         ST_PLAYBACK: begin
            if (frame_end && last_frame) begin
               state_next = ST_RETURN;
            end
         end
         ST_RETURN: begin
            // Wait for the bank to drop ready before arming again.
            if (!ready) begin
               state_next = ST_ARMED;
            end
         end
         default: begin
            state_next = ST_ARMED;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state        <= ST_ARMED;
         replay_count <= '0;
      end else begin
         state <= state_next;
         if (state != ST_PLAYBACK) begin
            replay_count <= '0;
         end else if (frame_end) begin
            replay_count <= last_frame ? '0 : replay_count + 1'b1;
         end
      end
   end

   assign mode    = (state == ST_PLAYBACK) ? MODE_PLAYBACK : MODE_WRITING;
   assign playing = (state == ST_PLAYBACK);

endmodule

// ==== capture_top.sv ====
`timescale 1ns/10ps

module capture_top
   import capture_pkg::*;
#(
   parameter int NUM_WORDS       = 64,
   parameter int SAMPLES_PER_ACQ = 256,
   parameter int DECIMATION      = 3,
   parameter int NUM_REPLAYS     = 2
) (
   input  logic    clk,
   input  logic    reset,
   input  sample_t sample_in,
   input  logic    sample_strobe,
   input  logic    trigger,
   output sample_t sample_out,
   output logic    sample_valid,
   output logic    frame_start,
   output logic    frame_end,
   output logic    ready,
   output logic    playing
);

   logic    data_available;
   sample_t dec_data;
   mode_t   mode;

   sample_decimator #(
      .DECIMATION(DECIMATION)
   ) decimator (
      .clk           (clk),
      .reset         (reset),
      .sample_in     (sample_in),
      .sample_strobe (sample_strobe),
      .data_available(data_available),
      .data          (dec_data)
   );

   acq_controller #(
      .NUM_REPLAYS(NUM_REPLAYS)
   ) controller (
      .clk      (clk),
      .reset    (reset),
      .trigger  (trigger),
      .ready    (ready),
      .frame_end(frame_end),
      .mode     (mode),
      .playing  (playing)
   );

   // Ready and frame_end also feed the controller.
   mem_bank #(
      .NUM_WORDS      (NUM_WORDS),
      .SAMPLES_PER_ACQ(SAMPLES_PER_ACQ)
   ) bank (
      .clk           (clk),
      .reset         (reset),
      .mode          (mode),
      .data_available(data_available),
      .data_in       (dec_data),
      .ready         (ready),
      .frame_start   (frame_start),
      .frame_end     (frame_end),
      .sample_valid  (sample_valid),
      .data_out      (sample_out)
   );

endmodule

// ==== tb_capture.sv ====
`timescale 1ns/10ps

module tb_capture;
   import capture_pkg::*;

   localparam int NUM_WORDS       = 64;
   localparam int SAMPLES_PER_ACQ = 256;
   localparam int DECIMATION      = 3;
   localparam int NUM_REPLAYS     = 2;
   localparam int ROUNDS          = 3;
   localparam int MAX_TARGET      = NUM_WORDS * SAMPLES_PER_WORD + 170;
   localparam int START_LIMIT     = 10;
   // Strobes come three cycles in four, so about 4 cycles per kept sample.
   localparam int ROUND_CYCLES    =
      MAX_TARGET * DECIMATION * 3 + NUM_REPLAYS * SAMPLES_PER_ACQ * 2 + 200;

   logic    clk = 1'b0;
   logic    reset;
   sample_t sample_in;
   logic    sample_strobe;
   logic    trigger;
   sample_t sample_out;
   logic    sample_valid;
   logic    frame_start;
   logic    frame_end;
   logic    ready;
   logic    playing;

   int      errors = 0;

   // Reference model state.
   int      strobe_phase;
   logic    dec_valid;
   sample_t dec_data;
   logic    play_exp;
   int      acq_count;
   sample_t captured[$];
   sample_t frame[$];
   int      frame_idx;
   int      frames_done;
   logic    streaming;
   int      start_wait;

   capture_top #(
      .NUM_WORDS      (NUM_WORDS),
      .SAMPLES_PER_ACQ(SAMPLES_PER_ACQ),
      .DECIMATION     (DECIMATION),
      .NUM_REPLAYS    (NUM_REPLAYS)
   ) DUT (
      .clk          (clk),
      .reset        (reset),
      .sample_in    (sample_in),
      .sample_strobe(sample_strobe),
      .trigger      (trigger),
      .sample_out   (sample_out),
      .sample_valid (sample_valid),
      .frame_start  (frame_start),
      .frame_end    (frame_end),
      .ready        (ready),
      .playing      (playing)
   );

   always #5 clk = ~clk;

   task automatic mismatch(input string name, input int expected, input int actual);
      errors++;
      $display("Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
   endtask

   task automatic failure(input string what);
      errors++;
      $display("Failure at %0t: %s", $time, what);
   endtask

   // Marks never appear without a sample.
   assert property (@(posedge clk) disable iff (reset)
      (frame_start || frame_end) |-> sample_valid)
      else failure("frame mark without sample_valid");

   // Frames run back to back until playback ends.
   assert property (@(posedge clk) disable iff (reset)
      frame_end |=> (frame_start || !playing))
      else failure("gap between frames");

   assert property (@(posedge clk) disable iff (reset) playing |-> !ready)
      else failure("ready high during playback");

   always @(posedge clk) begin
      logic ready_exp;
      logic play_next;
      int   kept;
      if (reset) begin
         strobe_phase = 0;
         dec_valid    = 1'b0;
         dec_data     = '0;
         play_exp     = 1'b0;
         acq_count    = 0;
         frame_idx    = 0;
         frames_done  = 0;
         streaming    = 1'b0;
         start_wait   = 0;
         captured.delete();
      end else begin
         ready_exp = !play_exp && (acq_count == SAMPLES_PER_ACQ);
         play_next = play_exp;
         assert (ready == ready_exp) else mismatch("ready", int'(ready_exp), int'(ready));
         assert (playing == play_exp) else mismatch("playing", int'(play_exp), int'(playing));

         if (play_exp && sample_valid) begin
            streaming = 1'b1;
            assert (sample_out == frame[frame_idx])
               else mismatch("sample_out", int'(frame[frame_idx]), int'(sample_out));
            assert (frame_start == (frame_idx == 0))
               else mismatch("frame_start", int'(frame_idx == 0), int'(frame_start));
            assert (frame_end == (frame_idx == SAMPLES_PER_ACQ - 1))
               else mismatch("frame_end", int'(frame_idx == SAMPLES_PER_ACQ - 1),
                             int'(frame_end));
            frame_idx++;
            if (frame_idx == SAMPLES_PER_ACQ) begin
               frame_idx = 0;
               frames_done++;
               // Controller leaves on the edge after the last frame_end.
               if (frames_done == NUM_REPLAYS) begin
                  play_next = 1'b0;
               end
            end
         end else if (play_exp) begin
            if (streaming) begin
               failure("sample_valid dropped inside playback");
               streaming = 1'b0;
            end
            start_wait++;
            if (start_wait == START_LIMIT) begin
               failure("first playback sample is late");
            end
         end else begin
            assert (!sample_valid) else mismatch("sample_valid", 0, int'(sample_valid));
         end

         if (!play_exp && trigger && ready_exp) begin
            // A word still being packed at the trigger is lost.
            kept = (captured.size() / SAMPLES_PER_WORD) * SAMPLES_PER_WORD;
            frame.delete();
            for (int i = kept - SAMPLES_PER_ACQ; i < kept; i++) begin
               frame.push_back(captured[i]);
            end
            captured.delete();
            acq_count   = 0;
            play_next   = 1'b1;
            frame_idx   = 0;
            frames_done = 0;
            streaming   = 1'b0;
            start_wait  = 0;
         end else if (!play_exp && dec_valid) begin
            captured.push_back(dec_data);
            if (acq_count < SAMPLES_PER_ACQ) begin
               acq_count++;
            end
         end

         // Decimator counts every strobe, in any mode.
         dec_valid = sample_strobe && (strobe_phase == 0);
         if (dec_valid) begin
            dec_data = sample_in;
         end
         if (sample_strobe) begin
            strobe_phase = (strobe_phase + 1) % DECIMATION;
         end
         play_exp = play_next;
      end
   end

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(negedge clk);
         sample_strobe = 1'b0;
         trigger       = 1'b0;
      end
   endtask

   task automatic strobe_until(input int target);
      logic early_sent;
      early_sent = 1'b0;
      while (captured.size() < target) begin
         @(negedge clk);
         sample_strobe = ($urandom_range(0, 3) != 0);
         sample_in     = sample_t'($urandom);
         trigger       = 1'b0;
         // Too early, ready is still low.
         if (!early_sent && captured.size() == SAMPLES_PER_ACQ / 2) begin
            trigger    = 1'b1;
            early_sent = 1'b1;
         end
      end
   endtask

   task automatic play_round();
      @(negedge clk);
      sample_strobe = 1'b0;
      trigger       = 1'b1;
      @(negedge clk);
      trigger = 1'b0;
      assert (playing) else failure("trigger with ready high did not start playback");
      while (playing) begin
         // Strobes and triggers during playback are ignored.
         sample_strobe = ($urandom_range(0, 1) != 0);
         sample_in     = sample_t'($urandom);
         trigger       = ($urandom_range(0, 31) == 0);
         @(negedge clk);
      end
      sample_strobe = 1'b0;
      trigger       = 1'b0;
      assert (frames_done == NUM_REPLAYS) else failure("wrong number of frames played");
      assert (!ready) else failure("ready high right after playback");
   endtask

   initial begin
      int target;
      void'($urandom(32'he55bfeaf));
      reset         = 1'b1;
      sample_in     = '0;
      sample_strobe = 1'b0;
      trigger       = 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      assert (!(ready || playing || sample_valid || frame_start || frame_end))
         else failure("control outputs not low after reset");

      for (int round = 0; round < ROUNDS; round++) begin
         // First round overfills the RAM so the ring wraps.
         if (round == 0) begin
            target = NUM_WORDS * SAMPLES_PER_WORD + 20 + $urandom_range(0, 150);
         end else begin
            target = SAMPLES_PER_ACQ + $urandom_range(0, 150);
         end
         strobe_until(target);
         idle_cycles(4);
         assert (ready) else failure("ready low after a full acquisition");
         play_round();
         idle_cycles(3);
      end

      $display("Run complete with %0d errors", errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   initial begin
      #(ROUNDS * ROUND_CYCLES * 10);
      $display("Watchdog expired after %0d cycles with %0d errors",
               ROUNDS * ROUND_CYCLES, errors);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

// ==== files.f ====
capture_pkg.sv
mem_bank_ram.sv
sample_decimator.sv
mem_bank.sv
acq_controller.sv
capture_top.sv
tb_capture.sv

// ==== Makefile ====
TOP = tb_capture

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^TESTS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
